// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_mem_front
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cache_warmup.sv ====
`timescale 1ns/1ps

module cache_warmup #(
    parameter int unsigned WARMUP_FETCHES = 3
) (
    input  logic Clk,
    input  logic i_reset,
    input  logic i_inst_ok,
    output logic o_cache_closed
);

    localparam int CNT_W = (WARMUP_FETCHES > 0) ? $clog2(WARMUP_FETCHES + 1) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_next;
    logic             closed_q;

    // one step per completed fetch, saturating at zero.
    always_comb begin
        cnt_next = cnt_q;
        if (i_inst_ok && (cnt_q != '0)) begin
            cnt_next = cnt_q - 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            cnt_q    <= CNT_W'(WARMUP_FETCHES);
            closed_q <= 1'b1;
        end else begin
            cnt_q    <= cnt_next;
            closed_q <= (cnt_next != '0);
        end
    end

    // opens on the edge that takes the last warm-up fetch.
    assign o_cache_closed = closed_q;

endmodule

// ==== cacheop_decode.sv ====
`timescale 1ns/1ps

module cacheop_decode (
    input  logic                      Clk,
    input  logic                      i_reset,
    input  logic                      i_exception,
    input  logic                      i_instr_valid,
    input  mem_front_pkg::word_t      i_instr,
    input  mem_front_pkg::word_t      i_addr,
    output mem_front_pkg::cache_cmd_t o_icache_cmd,
    output mem_front_pkg::cache_cmd_t o_dcache_cmd
);

    logic [1:0]                target;
    logic [2:0]                op_field;
    mem_front_pkg::cache_op_e  base_op;
    mem_front_pkg::cache_op_e  icache_op;
    mem_front_pkg::cache_op_e  dcache_op;
    logic                      take;

    logic                      ivld_q;
    logic                      dvld_q;
    mem_front_pkg::cache_op_e  iop_q;
    mem_front_pkg::cache_op_e  dop_q;
    mem_front_pkg::word_t      addr_q;

    assign target   = i_instr[mem_front_pkg::CACHEOP_TARGET_LSB +: 2];
    assign op_field = i_instr[mem_front_pkg::CACHEOP_OP_LSB +: 3];
    assign take     = i_instr_valid & ~i_exception;

    always_comb begin
        case (op_field)
            mem_front_pkg::OPC_INDEX_WB_INV:    base_op = mem_front_pkg::CACHE_INDEX_WB_INVALIDATE;
            mem_front_pkg::OPC_INDEX_STORE_TAG: base_op = mem_front_pkg::CACHE_INDEX_STORE_TAG;
            mem_front_pkg::OPC_HIT_INV:         base_op = mem_front_pkg::CACHE_HIT_INVALIDATE;
            mem_front_pkg::OPC_HIT_WB_INV:      base_op = mem_front_pkg::CACHE_HIT_WB_INVALIDATE;
            default:                            base_op = mem_front_pkg::CACHE_NOP;
        endcase
        // icache has no dirty lines, so no writeback form.
        icache_op = mem_front_pkg::CACHE_NOP;
        dcache_op = mem_front_pkg::CACHE_NOP;
        if (target == mem_front_pkg::TARGET_ICACHE &&
            base_op != mem_front_pkg::CACHE_HIT_WB_INVALIDATE) begin
            icache_op = base_op;
        end
        if (target == mem_front_pkg::TARGET_DCACHE) begin
            dcache_op = base_op;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            ivld_q <= 1'b0;
            dvld_q <= 1'b0;
        end else begin
            ivld_q <= take && (icache_op != mem_front_pkg::CACHE_NOP);
            dvld_q <= take && (dcache_op != mem_front_pkg::CACHE_NOP);
        end
    end

    always_ff @(posedge Clk) begin
        iop_q  <= icache_op;
        dop_q  <= dcache_op;
        addr_q <= i_addr;
    end

    assign o_icache_cmd = '{valid: ivld_q, op: iop_q, addr: addr_q};
    assign o_dcache_cmd = '{valid: dvld_q, op: dop_q, addr: addr_q};

    a_one_cache: assert property (@(posedge Clk)
        !(o_icache_cmd.valid && o_dcache_cmd.valid))
        else $error("icache and dcache commands issued together");

endmodule

// ==== compile.f ====
mem_front_pkg.sv
reset_stretch.sv
cache_warmup.sv
cacheop_decode.sv
mem_route.sv
mem_front_top.sv
tb_mem_front.sv

// ==== mem_front_pkg.sv ====
package mem_front_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic words.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    // encoded like the bus size field.
    typedef enum logic [2:0] {
        BYTE = 3'd0,
        HALF = 3'd1,
        WORD = 3'd2
    } acc_size_e;

    // access as it leaves the execute stage.
    typedef struct packed {
        logic      valid;
        logic      is_store;
        acc_size_e size;
        word_t     addr;
        word_t     wdata;
    } mem_req_t;

    // access on one cache channel, wdata already lane aligned.
    typedef struct packed {
        logic      valid;
        logic      is_store;
        acc_size_e size;
        byte_en_t  byte_en;
        word_t     addr;
        word_t     wdata;
    } mem_bus_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache maintenance.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        CACHE_NOP,
        CACHE_INDEX_WB_INVALIDATE,
        CACHE_INDEX_STORE_TAG,
        CACHE_HIT_INVALIDATE,
        CACHE_HIT_WB_INVALIDATE
    } cache_op_e;

    typedef struct packed {
        logic      valid;
        cache_op_e op;
        word_t     addr;
    } cache_cmd_t;

    // field positions inside the CACHE instruction word.
    localparam int CACHEOP_TARGET_LSB = 16;
    localparam int CACHEOP_OP_LSB     = 18;

    localparam logic [1:0] TARGET_ICACHE = 2'd0;
    localparam logic [1:0] TARGET_DCACHE = 2'd1;

    // op field codes.
    localparam logic [2:0] OPC_INDEX_WB_INV    = 3'b000;
    localparam logic [2:0] OPC_INDEX_STORE_TAG = 3'b010;
    localparam logic [2:0] OPC_HIT_INV         = 3'b100;
    localparam logic [2:0] OPC_HIT_WB_INV      = 3'b101;

    // top address bits of the unmapped uncached segment.
    localparam logic [2:0] KSEG1_TAG = 3'b101;

endpackage

// ==== mem_front_top.sv ====
`timescale 1ns/1ps

module mem_front_top #(
    parameter int unsigned RESET_HOLD_BITS = 7,
    parameter int unsigned WARMUP_FETCHES  = 3
) (
    input  logic                      Clk,
    input  logic                      reset,
    input  logic                      i_inst_ok,
    input  logic                      i_exception,
    input  mem_front_pkg::mem_req_t   i_mem_req,
    input  mem_front_pkg::word_t      i_cache_instr,
    input  logic                      i_cache_instr_valid,
    input  mem_front_pkg::word_t      i_cache_addr,
    output logic                      o_core_reset,
    output mem_front_pkg::mem_bus_t   o_cached_req,
    output mem_front_pkg::mem_bus_t   o_uncached_req,
    output logic                      o_align_err,
    output mem_front_pkg::cache_cmd_t o_icache_cmd,
    output mem_front_pkg::cache_cmd_t o_dcache_cmd
);

    logic core_reset;
    logic cache_closed;

    reset_stretch #(
        .RESET_HOLD_BITS(RESET_HOLD_BITS)
    ) u_reset_stretch (
        .Clk          (Clk),
        .reset        (reset),
        .o_core_reset (core_reset)
    );

    cache_warmup #(
        .WARMUP_FETCHES(WARMUP_FETCHES)
    ) u_cache_warmup (
        .Clk            (Clk),
        .i_reset        (core_reset),
        .i_inst_ok      (i_inst_ok),
        .o_cache_closed (cache_closed)
    );

    // cache maintenance path.
    cacheop_decode u_cacheop_decode (
        .Clk           (Clk),
        .i_reset       (core_reset),
        .i_exception   (i_exception),
        .i_instr_valid (i_cache_instr_valid),
        .i_instr       (i_cache_instr),
        .i_addr        (i_cache_addr),
        .o_icache_cmd  (o_icache_cmd),
        .o_dcache_cmd  (o_dcache_cmd)
    );

    // load/store path.
    mem_route u_mem_route (
        .Clk            (Clk),
        .i_reset        (core_reset),
        .i_exception    (i_exception),
        .i_cache_closed (cache_closed),
        .i_req          (i_mem_req),
        .o_cached       (o_cached_req),
        .o_uncached     (o_uncached_req),
        .o_align_err    (o_align_err)
    );

    assign o_core_reset = core_reset;

endmodule

// ==== mem_route.sv ====
`timescale 1ns/1ps

module mem_route (
    input  logic                    Clk,
    input  logic                    i_reset,
    input  logic                    i_exception,
    input  logic                    i_cache_closed,
    input  mem_front_pkg::mem_req_t i_req,
    output mem_front_pkg::mem_bus_t o_cached,
    output mem_front_pkg::mem_bus_t o_uncached,
    output logic                    o_align_err
);

    logic                    go;
    logic                    misaligned;
    logic                    uncached;
    mem_front_pkg::mem_bus_t bus_d;
    mem_front_pkg::mem_bus_t bus_q;
    logic                    cached_vld_q;
    logic                    uncached_vld_q;
    logic                    align_err_q;

    assign go = i_req.valid & ~i_exception;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alignment and segment.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign misaligned = ((i_req.size == mem_front_pkg::HALF) && i_req.addr[0]) ||
                        ((i_req.size == mem_front_pkg::WORD) && (i_req.addr[1:0] != 2'b00));

    // kseg1 is uncached, and so is everything until warm-up ends.
    assign uncached = (i_req.addr[31:29] == mem_front_pkg::KSEG1_TAG) | i_cache_closed;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lanes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        bus_d          = '0;
        bus_d.valid    = go;
        bus_d.is_store = i_req.is_store;
        bus_d.size     = i_req.size;
        bus_d.addr     = i_req.addr;
        if (i_req.is_store) begin
            case (i_req.size)
                mem_front_pkg::HALF: begin
                    bus_d.byte_en = i_req.addr[1] ? 4'b1100 : 4'b0011;
                    bus_d.wdata   = {2{i_req.wdata[15:0]}};
                end
                mem_front_pkg::WORD: begin
                    bus_d.byte_en = 4'b1111;
                    bus_d.wdata   = i_req.wdata;
                end
                default: begin
                    bus_d.byte_en = 4'b0001 << i_req.addr[1:0];
                    bus_d.wdata   = {4{i_req.wdata[7:0]}};
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            cached_vld_q   <= 1'b0;
            uncached_vld_q <= 1'b0;
            align_err_q    <= 1'b0;
        end else begin
            cached_vld_q   <= go & ~misaligned & ~uncached;
            uncached_vld_q <= go & ~misaligned & uncached;
            align_err_q    <= go & misaligned;
        end
    end

    always_ff @(posedge Clk) begin
        bus_q <= bus_d;
    end

    // both channels see the same payload, only one valid.
    always_comb begin
        o_cached             = bus_q;
        o_cached.valid       = cached_vld_q;
        o_uncached           = bus_q;
        o_uncached.valid     = uncached_vld_q;
    end

    assign o_align_err = align_err_q;

    a_one_channel: assert property (@(posedge Clk)
        !(o_cached.valid && o_uncached.valid))
        else $error("access sent on both channels");

    a_load_no_strobe: assert property (@(posedge Clk)
        ((o_cached.valid && !o_cached.is_store) ||
         (o_uncached.valid && !o_uncached.is_store)) |-> (bus_q.byte_en == 4'b0000))
        else $error("load issued with byte enables set");

endmodule

// ==== reset_stretch.sv ====
`timescale 1ns/1ps

module reset_stretch #(
    parameter int unsigned RESET_HOLD_BITS = 7
) (
    input  logic Clk,
    input  logic reset,
    output logic o_core_reset
);

    logic [RESET_HOLD_BITS-1:0] cnt_q;
    logic                       hold_q;

    // counter runs once through all values, then the hold drops.
    always_ff @(posedge Clk) begin
        if (reset) begin
            hold_q <= 1'b1;
            cnt_q  <= '0;
        end else if (hold_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (&cnt_q) begin
                hold_q <= 1'b0;
            end
        end
    end

    assign o_core_reset = reset | hold_q;

    // once released, the core only goes back into reset from the pin.
    a_no_spurious_reset: assert property (@(posedge Clk)
        $rose(o_core_reset) |-> reset)
        else $error("core reset rose without external reset");

endmodule

// ==== tb_mem_front.sv ====
`timescale 1ns/1ps

module tb_mem_front;

    localparam int unsigned HOLD_BITS   = 7;
    localparam int          HOLD_CYCLES = 1 << HOLD_BITS;
    localparam int          WARMUP      = 3;
    // about 130 reset cycles and 400 to 600 test cycles, with margin.
    localparam int          TIMEOUT_CYCLES = 2000;

    logic                      Clk = 1'b0;
    logic                      reset;
    logic                      inst_ok;
    logic                      exception;
    mem_front_pkg::mem_req_t   mem_req;
    mem_front_pkg::word_t      cache_instr;
    logic                      cache_instr_valid;
    mem_front_pkg::word_t      cache_addr;
    logic                      core_reset;
    mem_front_pkg::mem_bus_t   cached_req;
    mem_front_pkg::mem_bus_t   uncached_req;
    logic                      align_err;
    mem_front_pkg::cache_cmd_t icache_cmd;
    mem_front_pkg::cache_cmd_t dcache_cmd;

    int          cycle     = 0;
    int          errors    = 0;
    int          tests_ok  = 0;
    int          tests_bad = 0;
    logic [31:0] lfsr      = 32'd19;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    int                        rel_edges = 0;
    int                        ok_count  = 0;
    logic                      model_core_reset;
    mem_front_pkg::mem_req_t   prev_req;
    logic                      prev_exc;
    logic                      prev_core_reset;
    logic                      prev_closed;
    mem_front_pkg::word_t      prev_instr;
    logic                      prev_instr_valid;
    mem_front_pkg::word_t      prev_cache_addr;
    logic                      go;
    logic                      odd;
    logic                      unc;
    logic                      take;
    mem_front_pkg::mem_bus_t   exp_cached;
    mem_front_pkg::mem_bus_t   exp_uncached;
    mem_front_pkg::cache_cmd_t exp_icmd;
    mem_front_pkg::cache_cmd_t exp_dcmd;

    mem_front_top #(
        .RESET_HOLD_BITS(HOLD_BITS),
        .WARMUP_FETCHES (WARMUP)
    ) uut (
        .Clk                 (Clk),
        .reset               (reset),
        .i_inst_ok           (inst_ok),
        .i_exception         (exception),
        .i_mem_req           (mem_req),
        .i_cache_instr       (cache_instr),
        .i_cache_instr_valid (cache_instr_valid),
        .i_cache_addr        (cache_addr),
        .o_core_reset        (core_reset),
        .o_cached_req        (cached_req),
        .o_uncached_req      (uncached_req),
        .o_align_err         (align_err),
        .o_icache_cmd        (icache_cmd),
        .o_dcache_cmd        (dcache_cmd)
    );

    always #50 Clk = ~Clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic int size_bytes(input mem_front_pkg::acc_size_e sz);
        case (sz)
            mem_front_pkg::BYTE: return 1;
            mem_front_pkg::HALF: return 2;
            default:             return 4;
        endcase
    endfunction

    // an access must start on a multiple of its own size.
    function automatic logic misaligned(input mem_front_pkg::mem_req_t r);
        return (int'(r.addr[1:0]) % size_bytes(r.size)) != 0;
    endfunction

    function automatic mem_front_pkg::mem_bus_t expect_bus(input mem_front_pkg::mem_req_t r,
                                                          input logic vld);
        mem_front_pkg::mem_bus_t b;
        int n;
        int offs;
        int lane;
        n          = size_bytes(r.size);
        offs       = int'(r.addr[1:0]);
        b          = '0;
        b.valid    = vld;
        b.is_store = r.is_store;
        b.size     = r.size;
        b.addr     = r.addr;
        // each lane repeats the low bytes of the store data.
        for (lane = 0; lane < 4; lane++) begin
            if (r.is_store) begin
                b.byte_en[lane]      = (lane >= offs) && (lane < offs + n);
                b.wdata[lane*8 +: 8] = r.wdata[(lane % n)*8 +: 8];
            end
        end
        return b;
    endfunction

    function automatic mem_front_pkg::cache_cmd_t expect_cmd(input mem_front_pkg::word_t instr,
            input logic [1:0] side, input logic en, input mem_front_pkg::word_t addr);
        mem_front_pkg::cache_cmd_t c;
        c = '{valid: 1'b0, op: mem_front_pkg::CACHE_NOP, addr: addr};
        if (instr[mem_front_pkg::CACHEOP_TARGET_LSB +: 2] == side) begin
            case (instr[mem_front_pkg::CACHEOP_OP_LSB +: 3])
                3'b000:  c.op = mem_front_pkg::CACHE_INDEX_WB_INVALIDATE;
                3'b010:  c.op = mem_front_pkg::CACHE_INDEX_STORE_TAG;
                3'b100:  c.op = mem_front_pkg::CACHE_HIT_INVALIDATE;
                3'b101: begin
                    if (side == mem_front_pkg::TARGET_DCACHE) begin
                        c.op = mem_front_pkg::CACHE_HIT_WB_INVALIDATE;
                    end
                end
                default: c.op = mem_front_pkg::CACHE_NOP;
            endcase
        end
        c.valid = en && (c.op != mem_front_pkg::CACHE_NOP);
        return c;
    endfunction

    assign model_core_reset = reset || (rel_edges < HOLD_CYCLES);

    always @(posedge Clk) begin
        cycle <= cycle + 1;
        if (reset) begin
            rel_edges <= 0;
        end else if (rel_edges < HOLD_CYCLES) begin
            rel_edges <= rel_edges + 1;
        end
        if (model_core_reset) begin
            ok_count <= 0;
        end else if (inst_ok && ok_count < WARMUP) begin
            ok_count <= ok_count + 1;
        end
        prev_req         <= mem_req;
        prev_exc         <= exception;
        prev_core_reset  <= model_core_reset;
        prev_closed      <= (ok_count < WARMUP);
        prev_instr       <= cache_instr;
        prev_instr_valid <= cache_instr_valid;
        prev_cache_addr  <= cache_addr;
    end

    assign go           = prev_req.valid && !prev_exc && !prev_core_reset;
    assign odd          = misaligned(prev_req);
    assign unc          = (prev_req.addr[31:29] == mem_front_pkg::KSEG1_TAG) || prev_closed;
    assign take         = prev_instr_valid && !prev_exc && !prev_core_reset;
    assign exp_cached   = expect_bus(prev_req, go && !odd && !unc);
    assign exp_uncached = expect_bus(prev_req, go && !odd && unc);
    assign exp_icmd     = expect_cmd(prev_instr, mem_front_pkg::TARGET_ICACHE, take, prev_cache_addr);
    assign exp_dcmd     = expect_cmd(prev_instr, mem_front_pkg::TARGET_DCACHE, take, prev_cache_addr);

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_core_reset: assert property (@(posedge Clk) core_reset == model_core_reset)
        else flag_mismatch("core reset does not follow the hold count");
    a_cached: assert property (@(posedge Clk) disable iff (cycle < 3)
        cached_req.valid ? (cached_req == exp_cached) : !exp_cached.valid)
        else flag_mismatch("cached channel request differs from expected");
    a_uncached: assert property (@(posedge Clk) disable iff (cycle < 3)
        uncached_req.valid ? (uncached_req == exp_uncached) : !exp_uncached.valid)
        else flag_mismatch("uncached channel request differs from expected");
    a_align: assert property (@(posedge Clk) disable iff (cycle < 3)
        align_err == (go && odd))
        else flag_mismatch("alignment error strobe differs from expected");
    a_icache: assert property (@(posedge Clk) disable iff (cycle < 3)
        icache_cmd.valid ? (icache_cmd == exp_icmd) : !exp_icmd.valid)
        else flag_mismatch("icache command differs from expected");
    a_dcache: assert property (@(posedge Clk) disable iff (cycle < 3)
        dcache_cmd.valid ? (dcache_cmd == exp_dcmd) : !exp_dcmd.valid)
        else flag_mismatch("dcache command differs from expected");

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // misaligned requests only use HALF or WORD.
    task automatic rand_req(input logic kseg1, input logic aligned,
                            output mem_front_pkg::mem_req_t r);
        logic [31:0] v;
        r       = '0;
        r.valid = 1'b1;
        take_bits(2, v);
        if (v[1:0] == 2'd0 && aligned) begin
            r.size = mem_front_pkg::BYTE;
        end else if (v[0]) begin
            r.size = mem_front_pkg::HALF;
        end else begin
            r.size = mem_front_pkg::WORD;
        end
        take_bits(1, v);
        r.is_store = v[0];
        take_bits(32, v);
        r.addr = v;
        take_bits(32, v);
        r.wdata = v;
        if (kseg1) begin
            r.addr[31:29] = mem_front_pkg::KSEG1_TAG;
        end else if (r.addr[31:29] == mem_front_pkg::KSEG1_TAG) begin
            r.addr[31:29] = 3'b100;
        end
        if (aligned && r.size != mem_front_pkg::BYTE) begin
            r.addr[0] = 1'b0;
        end
        if (aligned && r.size == mem_front_pkg::WORD) begin
            r.addr[1] = 1'b0;
        end
        if (!aligned && !misaligned(r)) begin
            r.addr[0] = 1'b1;
        end
    endtask

    task automatic drive_idle();
        inst_ok           = 1'b0;
        exception         = 1'b0;
        mem_req           = '0;
        cache_instr_valid = 1'b0;
    endtask

    task automatic end_test(input string name, input int err_start);
        drive_idle();
        repeat (2) @(negedge Clk);
        if (errors == err_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d mismatches", name, errors - err_start);
        end
    endtask

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        mem_front_pkg::mem_req_t r;
        logic [31:0]             v;
        int                      mark;
        int                      i;
        reset       = 1'b1;
        cache_instr = '0;
        cache_addr  = '0;
        drive_idle();
        repeat (2) @(negedge Clk);
        reset = 1'b0;

        // core still held, so all of this is ignored.
        mark = errors;
        while (core_reset) begin
            rand_req(1'b0, 1'b1, r);
            mem_req           = r;
            inst_ok           = 1'b1;
            cache_instr_valid = 1'b1;
            @(negedge Clk);
        end
        end_test("reset_hold", mark);

        mark = errors;
        for (i = 0; i < 12; i++) begin
            rand_req(i % 2 == 1, 1'b1, r);
            mem_req = r;
            inst_ok = (i == 2) || (i == 5) || (i == 8);
            @(negedge Clk);
        end
        end_test("warmup_gate", mark);

        mark = errors;
        for (i = 0; i < 120; i++) begin
            take_bits(1, v);
            rand_req(v[0], 1'b1, r);
            r.valid = (i % 8 != 7);
            mem_req = r;
            @(negedge Clk);
        end
        end_test("aligned_access", mark);

        // byte accesses at every offset close the run.
        mark = errors;
        for (i = 0; i < 48; i++) begin
            take_bits(1, v);
            rand_req(v[0], i >= 40, r);
            if (i >= 40) begin
                r.size      = mem_front_pkg::BYTE;
                r.addr[1:0] = i[1:0];
            end
            mem_req = r;
            @(negedge Clk);
        end
        end_test("misaligned", mark);

        mark = errors;
        for (i = 0; i < 30; i++) begin
            take_bits(2, v);
            rand_req(v[0], v[1], r);
            mem_req   = r;
            exception = 1'b1;
            take_bits(32, v);
            cache_instr = v;
            cache_instr[mem_front_pkg::CACHEOP_OP_LSB +: 3]     = 3'b000;
            cache_instr[mem_front_pkg::CACHEOP_TARGET_LSB +: 2] = {1'b0, v[5]};
            cache_instr_valid = 1'b1;
            cache_addr        = r.addr;
            @(negedge Clk);
        end
        end_test("exception_cancel", mark);

        mark = errors;
        for (i = 0; i < 32; i++) begin
            take_bits(32, v);
            cache_instr = v;
            cache_instr[mem_front_pkg::CACHEOP_OP_LSB +: 3]     = i[4:2];
            cache_instr[mem_front_pkg::CACHEOP_TARGET_LSB +: 2] = i[1:0];
            cache_instr_valid = 1'b1;
            take_bits(32, v);
            cache_addr = v;
            @(negedge Clk);
        end
        end_test("cacheop_sweep", mark);

        $display("summary: %0d tests ok, %0d tests failed, %0d mismatches",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
